//--- list.f
src/ppu_pkg.sv
src/raster_timing.sv
src/scroll_counter.sv
src/bg_fetch.sv
src/bg_shifter.sv
src/ppu_render.sv
testbench/ppu_render_properties.sv
testbench/tb_ppu_render.sv

//--- src/bg_fetch.sv
`timescale 1ns/1ps

module bg_fetch (
	input  logic                sysclk,
	input  logic                ppu_clock,
	input  ppu_pkg::scroll_t    v_addr,
	input  logic                bg_ptable_addr,
	input  ppu_pkg::vram_data_t vram_datain,
	input  ppu_pkg::dot_t       dot_number,
	input  logic                fetch_tiles,
	input  logic                fetch_lines,
	output ppu_pkg::vram_addr_t vram_addrout,
	output ppu_pkg::vram_data_t low_plane,
	output logic [1:0]          attr_bits
);
	import ppu_pkg::*;

	logic [2:0]  slot_phase;
	fetch_slot_e slot;
	vram_data_t  pattern_index;
	vram_addr_t  next_addr;
	logic [2:0]  quad_base;

	// ----------------------------------------------------------------------
	// slot decode
	// odd dots issue an address and the following even dot takes the data,
	// so dots 1/2 map to the nametable slot and dots 7/0 to the high plane
	// ----------------------------------------------------------------------
	assign slot_phase = dot_number[2:0] - 3'd1;
	assign slot = fetch_slot_e'(slot_phase[2:1]);

	always_comb begin
		unique case (slot)
			slot_nametable: next_addr = {nametable_base, v_addr.vert_nt, v_addr.horiz_nt,
				v_addr.coarse_y, v_addr.coarse_x};
			slot_attribute: next_addr = {nametable_base, v_addr.vert_nt, v_addr.horiz_nt,
				attribute_row, v_addr.coarse_y[4:2], v_addr.coarse_x[4:2]};
			slot_pattern_low: next_addr = {1'b0, bg_ptable_addr, pattern_index,
				1'b0, v_addr.fine_y};
			slot_pattern_high: next_addr = {1'b0, bg_ptable_addr, pattern_index,
				1'b1, v_addr.fine_y};
		endcase
	end

	// address register follows every sysclk inside the fetch windows
	always_ff @(posedge sysclk) begin
		if (fetch_tiles && fetch_lines && dot_number[0])
			vram_addrout <= next_addr;
	end

	// ----------------------------------------------------------------------
	// data latches
	// ----------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (ppu_clock && !dot_number[0]) begin
			if (slot == slot_nametable)
				pattern_index <= vram_datain;          // tile number
			if (slot == slot_pattern_low)
				low_plane <= vram_datain;              // plane 0 waits for plane 1
		end
	end

	// one attribute byte covers 4x4 tiles, pick the 2x2 quadrant
	assign quad_base = {v_addr.coarse_y[1], v_addr.coarse_x[1], 1'b0};
	assign attr_bits = vram_datain[quad_base +: 2];

endmodule

//--- src/bg_shifter.sv
`timescale 1ns/1ps

module bg_shifter (
	input  logic                sysclk,
	input  logic                reset,
	input  logic                ppu_clock,
	input  logic                fetch_tiles,
	input  logic                load_tick,
	input  ppu_pkg::dot_t       dot_number,
	input  ppu_pkg::vram_data_t low_plane,
	input  logic [1:0]          attr_bits,
	input  ppu_pkg::vram_data_t vram_datain,
	input  logic [2:0]          fine_x_tmp,
	input  logic                show_background,
	input  logic                show_background_left,
	output ppu_pkg::bg_index_t  pixel_color_index
);
	import ppu_pkg::*;

	logic [15:0] pattern_shift0;
	logic [15:0] pattern_shift1;
	logic [1:0]  attr_stage;        // fetched for the tile after next
	logic [1:0]  attr_live;         // feeds the palette shifters
	logic [7:0]  palette_shift0;
	logic [7:0]  palette_shift1;
	logic [2:0]  tap;
	logic        show_here;

	// ----------------------------------------------------------------------
	// pattern shifters, msb is the pixel on screen
	// ----------------------------------------------------------------------
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			pattern_shift0 <= '0;
			pattern_shift1 <= '0;
		end else if (ppu_clock && fetch_tiles) begin
			if (load_tick) begin
				pattern_shift0 <= {pattern_shift0[14:7], low_plane};  // shift and load
				pattern_shift1 <= {pattern_shift1[14:7], vram_datain};
			end else begin
				pattern_shift0 <= {pattern_shift0[14:0], 1'b0};
				pattern_shift1 <= {pattern_shift1[14:0], 1'b0};
			end
		end
	end

	// ----------------------------------------------------------------------
	// palette path
	// ----------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (ppu_clock) begin
			if (dot_number[2:0] == 3'd4)
				attr_stage <= attr_bits;           // attribute byte on the bus
			else if (load_tick)
				attr_live <= attr_stage;
		end
	end

	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			palette_shift0 <= '0;
			palette_shift1 <= '0;
		end else if (ppu_clock && fetch_tiles) begin
			palette_shift0 <= {palette_shift0[6:0], attr_live[0]};
			palette_shift1 <= {palette_shift1[6:0], attr_live[1]};
		end
	end

	// fine x counts from the msb
	assign tap = ~fine_x_tmp;
	assign show_here = show_background && (dot_number > left_mask_dots || show_background_left);
	assign pixel_color_index = show_here ?
		{palette_shift1[tap], palette_shift0[tap],
		 pattern_shift1[{1'b1, tap}], pattern_shift0[{1'b1, tap}]} : '0;

endmodule

//--- src/ppu_pkg.sv
package ppu_pkg;

	// ----------------------------------------------------------------------
	// bus and raster types
	// ----------------------------------------------------------------------
	typedef logic [8:0] dot_t;          // 0..340
	typedef logic [8:0] line_t;         // 0..261
	typedef logic [13:0] vram_addr_t;
	typedef logic [7:0] vram_data_t;
	typedef logic [3:0] bg_index_t;     // {palette[1:0], pattern[1:0]}

	// loopy style scroll address, same bit order as the 15-bit register
	typedef struct packed {
		logic [2:0] fine_y;
		logic       vert_nt;
		logic       horiz_nt;
		logic [4:0] coarse_y;
		logic [4:0] coarse_x;
	} scroll_t;

	// four memory accesses per 8-dot tile
	typedef enum logic [1:0] {
		slot_nametable,
		slot_attribute,
		slot_pattern_low,
		slot_pattern_high
	} fetch_slot_e;

	// ----------------------------------------------------------------------
	// raster geometry
	// ----------------------------------------------------------------------
	localparam dot_t last_dot = 9'd340;
	localparam line_t last_line = 9'd261;       // pre-render line
	localparam dot_t visible_dots = 9'd256;
	localparam dot_t horiz_reload_dot = 9'd257;
	localparam dot_t vert_step_dot = 9'd251;
	localparam dot_t vert_reload_dot = 9'd280;
	localparam dot_t prefetch_start_dot = 9'd320;  // first two tiles of next line
	localparam dot_t prefetch_stop_dot = 9'd336;
	localparam line_t first_visible_line = 9'd7;
	localparam line_t end_visible_line = 9'd232;
	localparam line_t last_fetch_line = 9'd239;
	localparam dot_t left_mask_dots = 9'd8;

	// memory map
	localparam logic [1:0] nametable_base = 2'b10;   // $2000 region
	localparam logic [3:0] attribute_row = 4'b1111;  // attribute table at $23C0 and up
	localparam logic [4:0] last_coarse_row = 5'd29;

endpackage

//--- src/ppu_render.sv
`timescale 1ns/1ps

module ppu_render (
	input  logic                sysclk,
	input  logic                reset,
	input  logic                ppu_clock,
	input  logic                load_v,
	input  ppu_pkg::scroll_t    vram_tmp,
	input  logic [2:0]          fine_x_tmp,
	input  logic                show_background,
	input  logic                show_background_left,
	input  logic                bg_ptable_addr,       // 0 is $0000, 1 is $1000
	input  ppu_pkg::vram_data_t vram_datain,
	output ppu_pkg::vram_addr_t vram_addrout,
	output ppu_pkg::dot_t       dot_number,
	output ppu_pkg::line_t      line_number,
	output logic                dot_visible,
	output logic                line_visible,
	output ppu_pkg::bg_index_t  pixel_color_index
);
	import ppu_pkg::*;

	logic       fetch_tiles;
	logic       fetch_lines;
	logic       load_tick;
	scroll_t    v_addr;
	vram_data_t low_plane;
	logic [1:0] attr_bits;

	// ----------------------------------------------------------------------
	// background pipeline
	// ----------------------------------------------------------------------
	raster_timing u_raster_timing (
		.sysclk(sysclk), .reset(reset), .ppu_clock(ppu_clock),
		.dot_number(dot_number), .line_number(line_number),
		.dot_visible(dot_visible), .line_visible(line_visible),
		.fetch_tiles(fetch_tiles), .fetch_lines(fetch_lines),
		.pre_render_line(),                       // only the sprite side needed it
		.load_tick(load_tick)
	);

	scroll_counter u_scroll_counter (
		.sysclk(sysclk), .reset(reset), .ppu_clock(ppu_clock),
		.load_v(load_v), .vram_tmp(vram_tmp), .show_background(show_background),
		.dot_number(dot_number), .line_number(line_number), .load_tick(load_tick),
		.v_addr(v_addr)
	);

	bg_fetch u_bg_fetch (
		.sysclk(sysclk), .ppu_clock(ppu_clock), .v_addr(v_addr),
		.bg_ptable_addr(bg_ptable_addr), .vram_datain(vram_datain),
		.dot_number(dot_number), .fetch_tiles(fetch_tiles), .fetch_lines(fetch_lines),
		.vram_addrout(vram_addrout), .low_plane(low_plane), .attr_bits(attr_bits)
	);

	bg_shifter u_bg_shifter (
		.sysclk(sysclk), .reset(reset), .ppu_clock(ppu_clock),
		.fetch_tiles(fetch_tiles), .load_tick(load_tick), .dot_number(dot_number),
		.low_plane(low_plane), .attr_bits(attr_bits), .vram_datain(vram_datain),
		.fine_x_tmp(fine_x_tmp), .show_background(show_background),
		.show_background_left(show_background_left),
		.pixel_color_index(pixel_color_index)
	);

endmodule

//--- src/raster_timing.sv
`timescale 1ns/1ps

module raster_timing (
	input  logic           sysclk,
	input  logic           reset,
	input  logic           ppu_clock,
	output ppu_pkg::dot_t  dot_number,
	output ppu_pkg::line_t line_number,
	output logic           dot_visible,
	output logic           line_visible,
	output logic           fetch_tiles,
	output logic           fetch_lines,
	output logic           pre_render_line,
	output logic           load_tick
);
	import ppu_pkg::*;

	// ----------------------------------------------------------------------
	// dot and line counters
	// ----------------------------------------------------------------------
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			dot_number <= '0;
			line_number <= '0;
		end else if (ppu_clock) begin
			if (dot_number == last_dot) begin
				dot_number <= '0;
				if (line_number == last_line)
					line_number <= '0;               // next frame
				else
					line_number <= line_number + 9'd1;
			end else begin
				dot_number <= dot_number + 9'd1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// window flags, each one tick behind the counter value it decodes
	// ----------------------------------------------------------------------
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			dot_visible <= 1'b0;
			fetch_tiles <= 1'b0;
			load_tick <= 1'b0;
		end else if (ppu_clock) begin
			if (dot_number == 9'd0)
				dot_visible <= 1'b1;
			else if (dot_number == visible_dots)
				dot_visible <= 1'b0;
			if (dot_number == 9'd0 || dot_number == prefetch_start_dot)
				fetch_tiles <= 1'b1;
			else if (dot_number == visible_dots || dot_number == prefetch_stop_dot)
				fetch_tiles <= 1'b0;
			load_tick <= (dot_number[2:0] == 3'b111);  // high plane arrives now
		end
	end

	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			line_visible <= 1'b0;
			fetch_lines <= 1'b0;
			pre_render_line <= 1'b0;
		end else if (ppu_clock) begin
			if (line_number == first_visible_line)
				line_visible <= 1'b1;
			else if (line_number == end_visible_line)
				line_visible <= 1'b0;
			if (line_number == last_line)
				fetch_lines <= 1'b1;                    // prefetch for line 0
			else if (line_number == last_fetch_line)
				fetch_lines <= 1'b0;
			pre_render_line <= (line_number == last_line);
		end
	end

endmodule

//--- src/scroll_counter.sv
`timescale 1ns/1ps

module scroll_counter (
	input  logic             sysclk,
	input  logic             reset,
	input  logic             ppu_clock,
	input  logic             load_v,
	input  ppu_pkg::scroll_t vram_tmp,
	input  logic             show_background,
	input  ppu_pkg::dot_t    dot_number,
	input  ppu_pkg::line_t   line_number,
	input  logic             load_tick,
	output ppu_pkg::scroll_t v_addr
);
	import ppu_pkg::*;

	logic coarse_x_step;
	logic vert_reload;

	// one step per tile in the visible part, plus the two prefetch tiles
	assign coarse_x_step = (load_tick && dot_number < horiz_reload_dot) ||
		dot_number == prefetch_start_dot + 9'd8 ||
		dot_number == prefetch_stop_dot;

	assign vert_reload = dot_number == vert_reload_dot && line_number == last_line;

	// ----------------------------------------------------------------------
	// current scroll address
	// ----------------------------------------------------------------------
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			v_addr <= '0;
		end else if (load_v) begin
			v_addr <= vram_tmp;                        // cpu write, not tick paced
		end else if (ppu_clock && show_background) begin
			// horizontal part
			if (dot_number == horiz_reload_dot) begin
				v_addr.coarse_x <= vram_tmp.coarse_x;
				v_addr.horiz_nt <= vram_tmp.horiz_nt;
			end else if (coarse_x_step) begin
				v_addr.coarse_x <= v_addr.coarse_x + 5'd1;  // 31 rolls over to 0
				if (&v_addr.coarse_x)
					v_addr.horiz_nt <= ~v_addr.horiz_nt;
			end

			// vertical part
			if (vert_reload) begin
				v_addr.fine_y <= vram_tmp.fine_y;
				v_addr.coarse_y <= vram_tmp.coarse_y;
				v_addr.vert_nt <= vram_tmp.vert_nt;
			end else if (dot_number == vert_step_dot) begin
				if (v_addr.fine_y != 3'd7) begin
					v_addr.fine_y <= v_addr.fine_y + 3'd1;
				end else begin
					v_addr.fine_y <= 3'd0;
					if (v_addr.coarse_y == last_coarse_row) begin
						v_addr.coarse_y <= 5'd0;
						v_addr.vert_nt <= ~v_addr.vert_nt;  // bottom of nametable
					end else begin
						// rows 30 and 31 sit in attribute space, 31 wraps without toggle
						v_addr.coarse_y <= v_addr.coarse_y + 5'd1;
					end
				end
			end
		end
	end

endmodule

//--- testbench/ppu_render_properties.sv
`timescale 1ns/1ps

module ppu_render_properties (
	input logic                sysclk,
	input logic                reset,
	input logic                ppu_clock,
	input ppu_pkg::dot_t       dot_number,
	input ppu_pkg::line_t      line_number,
	input logic                dot_visible,
	input logic                fetch_tiles,
	input logic                fetch_lines,
	input ppu_pkg::vram_addr_t vram_addrout
);
	import ppu_pkg::*;

	int failures = 0;   // count of failed assertions

	// ----------------------------------------------------------------------
	// raster counters and flags
	// ----------------------------------------------------------------------
	counter_range: assert property (@(posedge sysclk) disable iff (!reset)
		dot_number <= last_dot && line_number <= last_line)
		else begin
			$error("raster counter out of range, dot %0d line %0d", dot_number, line_number);
			failures = failures + 1;
		end

	visible_window: assert property (@(posedge sysclk) disable iff (!reset)
		dot_number > horiz_reload_dot |-> !dot_visible)
		else begin
			$error("dot_visible high at dot %0d", dot_number);
			failures = failures + 1;
		end

	// nametable fetch lands in the $2000 region
	nametable_issue: assert property (@(posedge sysclk) disable iff (!reset)
		ppu_clock && fetch_tiles && fetch_lines && dot_number[2:0] == 3'd1
		|=> vram_addrout[13:12] == nametable_base)
		else begin
			$error("nametable fetch outside the nametable region, address %h", vram_addrout);
			failures = failures + 1;
		end

endmodule

//--- testbench/ppu_stimulus.txt
// vram_tmp fine_x data_byte show_bg show_left inner_pixel left_pixel first_nt_addr
// a row with vram_tmp bit 15 set ends the table
0000 0 FF 1 1 F F 2000
001F 3 FF 1 1 F F 201F
7BAD 5 FF 1 0 F 0 2BAD
0C15 7 00 1 1 0 0 2C15
3456 2 FF 0 1 0 0 2456
05E0 1 00 0 0 0 0 25E0
4A3C 6 FF 1 0 F 0 2A3C
03FF 4 FF 1 1 F F 23FF
1234 0 00 1 0 0 0 2234
6ABF 3 FF 1 1 F F 2ABF
8000 0 00 0 0 0 0 0000

//--- testbench/tb_ppu_render.sv
`timescale 1ns/1ps

module tb_ppu_render;
	import ppu_pkg::*;

	logic        sysclk = 1'b0;
	logic        reset;
	logic        ppu_clock = 1'b0;
	logic        load_v;
	logic [14:0] vram_tmp;
	logic [2:0]  fine_x_tmp;
	logic        show_background;
	logic        show_background_left;
	logic        bg_ptable_addr;
	logic [7:0]  vram_datain;
	logic [13:0] vram_addrout;
	logic [8:0]  dot_number;
	logic [8:0]  line_number;
	logic        dot_visible;
	logic        line_visible;
	logic [3:0]  pixel_color_index;

	logic [7:0]  mem_byte;
	logic [15:0] stim_words [0:127];   // 8 words per row, up to 16 rows
	int          row_count = 0;
	int          rows_found;
	bit          marker_seen;
	int          scan;
	int          line_dots;
	int          frame_lines;
	int          frame_ticks = 0;
	int          tick_count;
	int          tick_wait;
	integer      seed = 40;
	logic [13:0] expect_addr;
	logic [3:0]  expect_inner;
	logic [3:0]  expect_left;

	ppu_render dut (
		.sysclk(sysclk), .reset(reset), .ppu_clock(ppu_clock), .load_v(load_v),
		.vram_tmp(vram_tmp), .fine_x_tmp(fine_x_tmp), .show_background(show_background),
		.show_background_left(show_background_left), .bg_ptable_addr(bg_ptable_addr),
		.vram_datain(vram_datain), .vram_addrout(vram_addrout), .dot_number(dot_number),
		.line_number(line_number), .dot_visible(dot_visible), .line_visible(line_visible),
		.pixel_color_index(pixel_color_index)
	);

	bind ppu_render ppu_render_properties u_props (
		.sysclk(sysclk), .reset(reset), .ppu_clock(ppu_clock),
		.dot_number(dot_number), .line_number(line_number), .dot_visible(dot_visible),
		.fetch_tiles(fetch_tiles), .fetch_lines(fetch_lines), .vram_addrout(vram_addrout)
	);

	// ----------------------------------------------------------------------
	// clock, tick enable and memory model
	// ----------------------------------------------------------------------
	always #10 sysclk = ~sysclk;

	always @(posedge sysclk) begin
		if (!reset) begin
			ppu_clock <= 1'b0;
			tick_wait <= 1;
		end else if (tick_wait == 0) begin
			ppu_clock <= 1'b1;
			tick_wait <= 1 + ($unsigned($random(seed)) % 2);  // one or two idle cycles
		end else begin
			ppu_clock <= 1'b0;
			tick_wait <= tick_wait - 1;
		end
	end

	always @(posedge sysclk) begin
		if (!reset)
			tick_count <= 0;
		else if (ppu_clock)
			tick_count <= tick_count + 1;
	end

	assign vram_datain = mem_byte;   // same byte at every address

	// a bound assertion failure ends the run at once
	always @(posedge sysclk) begin
		if (dut.u_props.failures != 0) begin
			$display("A bound assertion failed, the run stops here");
			$display("Verification failed");
			$fatal(1);
		end
	end

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------
	task automatic check_count(input ppu_pkg::dot_t actual, input ppu_pkg::dot_t expected,
		input string what);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic check_addr(input ppu_pkg::vram_addr_t actual,
		input ppu_pkg::vram_addr_t expected, input string what);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic check_pixel(input ppu_pkg::bg_index_t actual,
		input ppu_pkg::bg_index_t expected, input string what);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic wait_dot(input int target);
		@(negedge sysclk);
		while (dot_number !== target)
			@(negedge sysclk);
	endtask

	// coarse x in bits 4:0, wrapping past 31 moves to the other horizontal nametable
	function automatic logic [13:0] next_tile_addr(input logic [13:0] addr);
		if (addr[4:0] == 5'd31)
			next_tile_addr = {addr[13:11], ~addr[10], addr[9:5], 5'd0};
		else
			next_tile_addr = addr + 14'd1;
	endfunction

	// one full frame of ticks counted from reset
	task automatic count_frame();
		int dot_now;
		int prev_line;
		while (tick_count < frame_ticks) begin
			@(negedge sysclk);
			dot_now = tick_count % line_dots;
			prev_line = (tick_count == 0) ? 0 : ((tick_count - 1) / line_dots) % frame_lines;
			check_count(dot_number, dot_now, "dot_number");
			check_count(line_number, (tick_count / line_dots) % frame_lines, "line_number");
			// flags follow the counter value of the previous tick
			check_flag(dot_visible, dot_now >= 1 && dot_now <= visible_dots, "dot_visible");
			check_flag(line_visible,
				prev_line >= first_visible_line && prev_line < end_visible_line,
				"line_visible");
		end
	endtask

	task automatic run_row(input int row);
		int base;
		int d;
		base = 8 * row;
		wait_dot(300);                             // after the last vertical step
		@(posedge sysclk);
		vram_tmp <= stim_words[base][14:0];
		fine_x_tmp <= stim_words[base + 1][2:0];
		mem_byte <= stim_words[base + 2][7:0];
		show_background <= stim_words[base + 3][0];
		show_background_left <= stim_words[base + 4][0];
		expect_inner = stim_words[base + 5][3:0];
		expect_left = stim_words[base + 6][3:0];
		expect_addr = stim_words[base + 7][13:0];
		wait_dot(338);                             // prefetch steps are done
		@(posedge sysclk);
		load_v <= 1'b1;
		@(posedge sysclk);
		load_v <= 1'b0;
		for (d = 1; d <= 250; d++) begin
			wait_dot(d);
			if (d <= 8)
				check_pixel(pixel_color_index, expect_left,
					$sformatf("row %0d left pixel at dot %0d", row, d));
			else if (d >= 24 || !stim_words[base + 3][0])
				check_pixel(pixel_color_index, expect_inner,
					$sformatf("row %0d pixel at dot %0d", row, d));
			if (d % 8 == 2) begin
				check_addr(vram_addrout, expect_addr,
					$sformatf("row %0d nametable address at dot %0d", row, d));
				if (stim_words[base + 3][0])
					expect_addr = next_tile_addr(expect_addr);
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial begin
		reset = 1'b0;
		load_v = 1'b0;
		vram_tmp = '0;
		fine_x_tmp = '0;
		show_background = 1'b0;
		show_background_left = 1'b0;
		bg_ptable_addr = 1'b0;
		mem_byte = 8'h00;
		line_dots = last_dot + 1;
		frame_lines = last_line + 1;
		frame_ticks = line_dots * frame_lines;
		$readmemh("testbench/ppu_stimulus.txt", stim_words);
		rows_found = 0;
		marker_seen = 1'b0;
		for (scan = 0; scan < 16; scan++) begin
			if (!marker_seen && stim_words[8 * scan][15] === 1'b1)
				marker_seen = 1'b1;                // end of table
			else if (!marker_seen)
				rows_found++;
		end
		if (!marker_seen || rows_found == 0) begin
			$display("Stimulus file is missing, empty or has no end marker row");
			$display("Verification failed");
			$fatal(1);
		end
		row_count = rows_found;
		repeat (10) @(posedge sysclk);
		reset <= 1'b1;
		count_frame();
		for (scan = 0; scan < row_count; scan++)
			run_row(scan);
		repeat (4) @(posedge sysclk);
		if (dut.u_props.failures == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Bound assertions reported %0d failures", dut.u_props.failures);
			$display("Verification failed");
			$fatal(1);
		end
	end

	// two frames of the slowest tick rate per test row
	initial begin
		wait (row_count > 0);
		#(row_count * 2 * frame_ticks * 60);
		$display("Timeout: the test sequence did not finish, the DUT or testbench hung");
		$display("Verification failed");
		$fatal(1);
	end

endmodule
